/* tests/capture_vectors.txt */
// one packet per line, all hex: channel, header address, payload words,
// seconds, nanoseconds, payload seed; lines on different channels run together
0 00001000 0008 00000010 00000100 1a2b3c4d
1 00002000 0005 00000011 00000200 55aa55aa
0 00003000 0001 00000012 00000300 0badf00d
0 00004000 0004 00000013 00000400 12345678
1 00005000 0010 00000014 00000500 cafe0001
1 00006000 0003 00000015 00000600 80000000
0 00007000 000d 00000016 00000700 00ff00ff
1 00008000 0007 00000017 00000800 13579bdf
0 00009000 0002 00000018 00000900 2468ace0
1 0000a000 000c 00000019 00000a00 fedcba98
0 0000b000 0010 0000001a 00000b00 01010101
1 0000c000 0009 0000001b 00000c00 7f7f7f7f

/* pcap_capture.f */
+incdir+source
source/pcap_pkg.sv
source/pkt_fifo.sv
source/skid_buffer.sv
source/capture_writer.sv
source/burst_arbiter.sv
source/capture_top.sv
tests/capture_properties.sv
tests/capture_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run with Verilator, fail if the log reports a failure
rm -f sim.log
verilator --binary --timing --assert --top-module capture_tb -f pcap_capture.f \
    && ./obj_dir/Vcapture_tb > sim.log 2>&1 \
    || echo "build or simulation aborted" >> sim.log
cat sim.log
grep -q "TEST OK" sim.log || echo "TEST FAILED" >> sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0

/* tests/capture_tb.sv */
`timescale 1ns/1ps
`include "pcap_defs.svh"

module capture_tb;
    import pcap_pkg::*;

    localparam int N = `PCAP_CHANNELS;
    localparam int MAXV = 64;

    logic          clk;
    logic          reset;
    logic [N-1:0]  i_start;
    capture_desc_t i_desc [N];
    timestamp_t    i_time;
    logic [N-1:0]  i_pkt_valid;
    logic [31:0]   i_pkt_data [N];
    logic [N-1:0]  o_ready;
    logic [N-1:0]  o_done;
    logic          o_mem_write;
    mem_cmd_t      o_mem_cmd;
    logic          i_mem_waitrequest;

    int            v_ch [MAXV];
    capture_desc_t v_desc [MAXV];
    timestamp_t    v_time [MAXV];
    logic [31:0]   v_seed [MAXV];
    int            nvec;
    int            seed = 49137;

    logic [31:0]   mem [logic [31:0]];       // memory model contents
    logic [31:0]   exp_mem [logic [31:0]];
    logic [2:0]    exp_bc [logic [31:0]];    // keyed by burst start address
    logic [31:0]   next_burst [N];           // where each channel's next burst must start
    mem_cmd_t      burst_first;
    int            beat_idx;
    logic [31:0]   act_lo [N];
    logic [31:0]   act_hi [N];
    int            exp_beats [N];
    int            ch_beats [N];
    int            done_cnt [N];
    logic [N-1:0]  done_seen;
    int            errors;
    int            tests;
    int            cycles;
    int            cycle_limit;
    logic          run_on;

    capture_top UUT (
        .clk               (clk),
        .reset             (reset),
        .i_start           (i_start),
        .i_desc            (i_desc),
        .i_time            (i_time),
        .i_pkt_valid       (i_pkt_valid),
        .i_pkt_data        (i_pkt_data),
        .o_ready           (o_ready),
        .o_done            (o_done),
        .o_mem_write       (o_mem_write),
        .o_mem_cmd         (o_mem_cmd),
        .i_mem_waitrequest (i_mem_waitrequest)
    );

    always #20 clk = ~clk;

    task automatic check_word(input logic [31:0] exp, input logic [31:0] got, input string what);
        if (got !== exp) begin
            $display("** Error at %0t: %s expected %h got %h", $time, what, exp, got);
            errors++;
        end
    endtask

    // compares the burst fields only
    task automatic check_cmd(input mem_cmd_t exp, input mem_cmd_t got, input string what);
        if (got.addr !== exp.addr || got.burstcount !== exp.burstcount) begin
            $display("** Error at %0t: %s expected addr %h bc %0d got addr %h bc %0d",
                     $time, what, exp.addr, exp.burstcount, got.addr, got.burstcount);
            errors++;
        end
    endtask

    task automatic check_done(input int ch, input int exp, input int got, input string what);
        if (got != exp) begin
            $display("** Error at %0t: channel %0d %s expected %0d got %0d",
                     $time, ch, what, exp, got);
            errors++;
        end
    endtask

    task automatic read_vectors();
        int          fd;
        int          rc;
        string       line;
        int          ch;
        logic [31:0] addr;
        logic [15:0] len;
        logic [31:0] sec;
        logic [31:0] nsec;
        logic [31:0] lseed;
        nvec = 0;
        fd = $fopen("tests/capture_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file tests/capture_vectors.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            rc = $fgets(line, fd);
            if (rc > 0 && line.len() > 1 && line.substr(0, 1) != "//") begin
                rc = $sscanf(line, "%h %h %h %h %h %h", ch, addr, len, sec, nsec, lseed);
                if (rc == 6 && nvec < MAXV) begin
                    v_ch[nvec] = ch;
                    v_desc[nvec] = '{addr: addr, len: len};
                    v_time[nvec] = '{sec: sec, nsec: nsec};
                    v_seed[nvec] = lseed;
                    nvec++;
                end
            end
        end
        $fclose(fd);
    endtask

    // header words and burst sizes of one packet
    task automatic prepare(input int v);
        int          c;
        int          len;
        logic [31:0] a;
        c = v_ch[v];
        len = int'(v_desc[v].len);
        a = v_desc[v].addr;
        act_lo[c] = a;
        act_hi[c] = a + 32'd16 + 32'(4 * len);
        next_burst[c] = a;
        exp_beats[c] = 4 + len;
        ch_beats[c] = 0;
        done_cnt[c] = 0;
        exp_mem[a] = v_time[v].sec;
        exp_mem[a + 32'd4] = v_time[v].nsec;
        exp_mem[a + 32'd8] = {16'd0, v_desc[v].len};
        exp_mem[a + 32'd12] = {16'd0, v_desc[v].len};
        exp_bc[a] = 3'd4;
        for (int j = 0; 4 * j < len; j++) begin
            exp_bc[a + 32'd16 + 32'(16 * j)] = (len - 4 * j >= 4) ? 3'd4 : 3'(len - 4 * j);
        end
    endtask

    task automatic start_packet(input int v);
        int c;
        c = v_ch[v];
        @(negedge clk);
        while (!o_ready[c]) @(negedge clk);
        @(posedge clk);
        i_start[c] <= 1'b1;
        i_desc[c] <= v_desc[v];
        i_time <= v_time[v];
        @(posedge clk);
        i_start[c] <= 1'b0;
    endtask

    task automatic compare_image(input int v);
        logic [31:0] a;
        for (int k = 0; k < 4 + int'(v_desc[v].len); k++) begin
            a = v_desc[v].addr + 32'(4 * k);
            if (!mem.exists(a)) begin
                $display("no beat was ever written to address %h", a);
                errors++;
            end else begin
                check_word(exp_mem[a], mem[a], (k < 4) ? "header word" : "payload word");
            end
        end
        check_done(v_ch[v], 1, done_cnt[v_ch[v]], "done pulses");
    endtask

    // b < 0 runs a single packet
    task automatic run_group(input int a, input int b);
        int          err0;
        int          la;
        int          lb;
        logic [31:0] w;
        err0 = errors;
        prepare(a);
        la = int'(v_desc[a].len);
        lb = 0;
        if (b >= 0) begin
            prepare(b);
            lb = int'(v_desc[b].len);
        end
        for (int k = 0; k < la || k < lb; k++) begin
            @(posedge clk);
            i_pkt_valid <= '0;
            if (k < la) begin
                w = $random(seed) + v_seed[a];
                i_pkt_valid[v_ch[a]] <= 1'b1;
                i_pkt_data[v_ch[a]] <= w;
                exp_mem[v_desc[a].addr + 32'd16 + 32'(4 * k)] = w;
            end
            if (k < lb) begin
                w = $random(seed) + v_seed[b];
                i_pkt_valid[v_ch[b]] <= 1'b1;
                i_pkt_data[v_ch[b]] <= w;
                exp_mem[v_desc[b].addr + 32'd16 + 32'(4 * k)] = w;
            end
        end
        @(posedge clk);
        i_pkt_valid <= '0;
        start_packet(a);
        if (b >= 0) start_packet(b);
        while (done_cnt[v_ch[a]] == 0 || (b >= 0 && done_cnt[v_ch[b]] == 0)) @(posedge clk);
        repeat (3) @(posedge clk);   // lets the ready check after done run
        compare_image(a);
        if (b >= 0) compare_image(b);
        tests++;
        $display("test %0d: packet %0d%s %s", tests, a, (b >= 0) ? " with next" : "",
                 (errors == err0) ? "ok" : "failed");
    endtask

    // memory model sampling each beat that the next rising edge accepts
    always @(negedge clk) begin
        logic [31:0] a;
        int          bch;
        mem_cmd_t    want;
        if (reset && o_mem_write && !i_mem_waitrequest) begin
            if (beat_idx == 0) begin
                burst_first = o_mem_cmd;
                bch = -1;
                for (int c = 0; c < N; c++) begin
                    if (o_mem_cmd.addr >= act_lo[c] && o_mem_cmd.addr < act_hi[c]) bch = c;
                end
                if (bch >= 0 && exp_bc.exists(next_burst[bch])) begin
                    want = '{addr: next_burst[bch], burstcount: exp_bc[next_burst[bch]],
                             data: 32'd0};
                    check_cmd(want, o_mem_cmd, "burst start");
                    next_burst[bch] = next_burst[bch] + 32'd16;   // bursts of a channel in order
                end else begin
                    $display("a burst started at unexpected address %h", o_mem_cmd.addr);
                    errors++;
                end
            end else begin
                check_cmd(burst_first, o_mem_cmd, "beat inside burst");
            end
            a = burst_first.addr + 32'(4 * beat_idx);
            if (mem.exists(a)) begin
                $display("address %h was written twice", a);
                errors++;
            end
            mem[a] = o_mem_cmd.data;
            for (int c = 0; c < N; c++) begin
                if (a >= act_lo[c] && a < act_hi[c]) ch_beats[c]++;
            end
            beat_idx = (beat_idx + 1 >= int'(burst_first.burstcount)) ? 0 : beat_idx + 1;
        end
        for (int c = 0; c < N; c++) begin
            if (done_seen[c]) begin
                check_done(c, 1, int'(o_ready[c]), "ready after done");
                done_seen[c] = 1'b0;
            end
            if (reset && o_done[c]) begin
                done_cnt[c]++;
                check_done(c, exp_beats[c], ch_beats[c], "beats before done");
                done_seen[c] = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        i_mem_waitrequest <= reset && (($random(seed) & 3) == 0);
    end

    always @(posedge clk) begin
        if (run_on) begin
            cycles <= cycles + 1;
            if (cycles > cycle_limit) begin
                $display("timeout: the run did not finish within %0d cycles", cycle_limit);
                $display("TEST FAILED");
                $finish;
            end
        end
    end

    initial begin
        int total;
        int i;
        clk = 1'b0;
        reset = 1'b0;
        i_start = '0;
        i_desc[0] = '0;
        i_desc[1] = '0;
        i_time = '0;
        i_pkt_valid = '0;
        i_pkt_data[0] = '0;
        i_pkt_data[1] = '0;
        i_mem_waitrequest = 1'b0;
        beat_idx = 0;
        done_seen = '0;
        errors = 0;
        tests = 0;
        cycles = 0;
        run_on = 1'b0;
        for (int c = 0; c < N; c++) begin
            act_lo[c] = '0;
            act_hi[c] = '0;
            next_burst[c] = '0;
            exp_beats[c] = 0;
            ch_beats[c] = 0;
            done_cnt[c] = 0;
        end
        read_vectors();
        total = 0;
        for (int v = 0; v < nvec; v++) total += int'(v_desc[v].len);
        cycle_limit = 60 * nvec + 50 * total;
        repeat (2) @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
        check_done(0, 0, int'(o_mem_write), "write after reset");
        check_done(0, 0, int'(o_done != '0), "done after reset");
        run_on = 1'b1;
        i = 0;
        while (i < nvec) begin
            if (i + 1 < nvec && v_ch[i] != v_ch[i + 1]) begin
                run_group(i, i + 1);   // both channels at once
                i += 2;
            end else begin
                run_group(i, -1);
                i += 1;
            end
        end
        $display("tests run %0d, packets %0d, errors %0d", tests, nvec, errors);
        if (errors == 0 && nvec > 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* tests/capture_properties.sv */
`timescale 1ns/1ps
`include "pcap_defs.svh"

module capture_properties (
    input logic                                  clk,
    input logic                                  reset,
    input logic                                  i_mem_write,
    input pcap_pkg::mem_cmd_t                    i_mem_cmd,
    input logic                                  i_waitrequest,
    input logic                                  i_busy,
    input logic [$clog2(`PCAP_CHANNELS)-1:0]     i_grant
);
    logic [2:0] beats_open;   // beats accepted so far in the current burst

    always_ff @(posedge clk) begin
        if (!reset) begin
            beats_open <= '0;
        end else if (i_mem_write && !i_waitrequest) begin
            beats_open <= (beats_open + 1'b1 == i_mem_cmd.burstcount) ? '0
                                                                       : beats_open + 1'b1;
        end
    end

    // stalled beat held unchanged
    a_stall_stable: assert property (@(posedge clk) disable iff (!reset)
        i_mem_write && i_waitrequest |=> i_mem_write && $stable(i_mem_cmd.addr)
            && $stable(i_mem_cmd.burstcount))
        else $error("burst fields changed during waitrequest");

    a_burst_stable: assert property (@(posedge clk) disable iff (!reset)
        $past(i_busy) && i_busy && $past(i_mem_write) && i_mem_write
            |-> $stable(i_mem_cmd.addr) && $stable(i_mem_cmd.burstcount))
        else $error("burst fields changed inside a burst");

    // locked on one channel until burstcount beats have gone out
    a_grant_held: assert property (@(posedge clk) disable iff (!reset)
        beats_open != '0 |-> i_busy && (!$past(beats_open != '0) || $stable(i_grant)))
        else $error("grant moved in the middle of a burst");

    a_reset_idle: assert property (@(posedge clk) !reset |=> !i_mem_write)
        else $error("write active right after reset");

endmodule

bind burst_arbiter capture_properties u_props (
    .clk           (clk),
    .reset         (reset),
    .i_mem_write   (o_mem_write),
    .i_mem_cmd     (o_mem_cmd),
    .i_waitrequest (i_mem_waitrequest),
    .i_busy        (busy),
    .i_grant       (grant_q)
);

/* source/capture_top.sv */
`timescale 1ns/1ps
`include "pcap_defs.svh"

module capture_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [`PCAP_CHANNELS-1:0]     i_start,
    input  pcap_pkg::capture_desc_t       i_desc [`PCAP_CHANNELS],
    input  pcap_pkg::timestamp_t          i_time,
    input  logic [`PCAP_CHANNELS-1:0]     i_pkt_valid,
    input  logic [31:0]                   i_pkt_data [`PCAP_CHANNELS],
    output logic [`PCAP_CHANNELS-1:0]     o_ready,
    output logic [`PCAP_CHANNELS-1:0]     o_done,
    output logic                          o_mem_write,
    output pcap_pkg::mem_cmd_t            o_mem_cmd,
    input  logic                          i_mem_waitrequest
);
    import pcap_pkg::*;

    localparam int N = `PCAP_CHANNELS;

    logic [31:0]               fifo_data [N];
    logic [N-1:0]              fifo_empty;
    logic [`PCAP_USEDW_W-1:0]  fifo_usedw [N];
    logic [N-1:0]              fifo_rd;

    logic [N-1:0]              wr_valid;     // writer to skid buffer
    mem_cmd_t                  wr_cmd [N];
    logic [N-1:0]              wr_ready;

    logic [N-1:0]              arb_valid;    // skid buffer to arbiter
    mem_cmd_t                  arb_cmd [N];
    logic [N-1:0]              arb_ready;
    logic [N-1:0]              arb_accept;

    for (genvar c = 0; c < N; c++) begin : g_ch
        pkt_fifo u_fifo (
            .clk       (clk),
            .reset     (reset),
            .i_wr_en   (i_pkt_valid[c]),
            .i_wr_data (i_pkt_data[c]),
            .i_rd_en   (fifo_rd[c]),
            .o_rd_data (fifo_data[c]),
            .o_empty   (fifo_empty[c]),
            .o_full    (),   // source never overfills
            .o_usedw   (fifo_usedw[c])
        );

        capture_writer u_writer (
            .clk          (clk),
            .reset        (reset),
            .i_start      (i_start[c]),
            .i_desc       (i_desc[c]),
            .i_time       (i_time),
            .o_ready      (o_ready[c]),
            .o_done       (o_done[c]),
            .i_fifo_data  (fifo_data[c]),
            .i_fifo_empty (fifo_empty[c]),
            .i_fifo_usedw (fifo_usedw[c]),
            .o_fifo_rd    (fifo_rd[c]),
            .o_cmd_valid  (wr_valid[c]),
            .o_cmd        (wr_cmd[c]),
            .i_cmd_ready  (wr_ready[c]),
            .i_mem_accept (arb_accept[c])
        );

        skid_buffer u_skid (
            .clk     (clk),
            .reset   (reset),
            .i_valid (wr_valid[c]),
            .i_data  (wr_cmd[c]),
            .o_ready (wr_ready[c]),
            .o_valid (arb_valid[c]),
            .o_data  (arb_cmd[c]),
            .i_ready (arb_ready[c])
        );
    end

    burst_arbiter u_arb (
        .clk               (clk),
        .reset             (reset),
        .i_req_valid       (arb_valid),
        .i_req_cmd         (arb_cmd),
        .o_req_ready       (arb_ready),
        .o_req_accept      (arb_accept),
        .o_mem_write       (o_mem_write),
        .o_mem_cmd         (o_mem_cmd),
        .i_mem_waitrequest (i_mem_waitrequest)
    );

endmodule

/* source/burst_arbiter.sv */
`timescale 1ns/1ps
`include "pcap_defs.svh"

module burst_arbiter (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [`PCAP_CHANNELS-1:0]     i_req_valid,
    input  pcap_pkg::mem_cmd_t            i_req_cmd [`PCAP_CHANNELS],
    output logic [`PCAP_CHANNELS-1:0]     o_req_ready,
    output logic [`PCAP_CHANNELS-1:0]     o_req_accept,
    output logic                          o_mem_write,
    output pcap_pkg::mem_cmd_t            o_mem_cmd,
    input  logic                          i_mem_waitrequest
);
    localparam int N = `PCAP_CHANNELS;
    localparam int CW = (N > 1) ? $clog2(N) : 1;

    logic          busy;         // grant locked until the burst ends
    logic [CW-1:0] grant_q;
    logic [CW-1:0] prio;         // first channel looked at
    logic [CW-1:0] pick;
    logic [CW-1:0] cur;
    logic [CW-1:0] prio_next;
    logic          found;
    logic [2:0]    beats_left;
    logic          accept;
    int            idx;

    // round-robin search from prio
    always_comb begin
        pick = prio;
        found = 1'b0;
        for (int k = 0; k < N; k++) begin
            idx = (int'(prio) + k) % N;
            if (!found && i_req_valid[idx]) begin
                pick = CW'(idx);
                found = 1'b1;
            end
        end
    end

    assign cur = busy ? grant_q : pick;
    assign prio_next = (cur == CW'(N - 1)) ? '0 : cur + 1'b1;

    assign o_mem_write = (busy || found) && i_req_valid[cur];
    assign o_mem_cmd = i_req_cmd[cur];
    assign accept = o_mem_write && !i_mem_waitrequest;

    always_comb begin
        for (int c = 0; c < N; c++) begin
            o_req_ready[c] = (cur == CW'(c)) && (busy || found) && !i_mem_waitrequest;
            o_req_accept[c] = (cur == CW'(c)) && accept;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            busy <= 1'b0;
            grant_q <= '0;
            prio <= '0;
            beats_left <= '0;
        end else if (!busy) begin
            if (o_mem_write) begin
                grant_q <= pick;
                if (accept && o_mem_cmd.burstcount == 3'd1) begin
                    prio <= prio_next;   // single-beat burst done
                end else begin
                    busy <= 1'b1;   // also locks a stalled first beat
                    beats_left <= accept ? o_mem_cmd.burstcount - 1'b1
                                         : o_mem_cmd.burstcount;
                end
            end
        end else if (accept) begin
            beats_left <= beats_left - 1'b1;
            if (beats_left == 3'd1) begin
                busy <= 1'b0;
                prio <= prio_next;
            end
        end
    end

endmodule

/* source/capture_writer.sv */
`timescale 1ns/1ps
`include "pcap_defs.svh"

module capture_writer (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        i_start,
    input  pcap_pkg::capture_desc_t     i_desc,
    input  pcap_pkg::timestamp_t        i_time,
    output logic                        o_ready,
    output logic                        o_done,
    input  logic [31:0]                 i_fifo_data,
    input  logic                        i_fifo_empty,
    input  logic [`PCAP_USEDW_W-1:0]    i_fifo_usedw,
    output logic                        o_fifo_rd,
    output logic                        o_cmd_valid,
    output pcap_pkg::mem_cmd_t          o_cmd,
    input  logic                        i_cmd_ready,
    input  logic                        i_mem_accept
);
    import pcap_pkg::*;

    localparam int UW = `PCAP_USEDW_W;
    localparam int BURST_BYTES = `PCAP_BURST_MAX * 4;

    writer_state_e state;
    writer_state_e state_next;
    capture_desc_t desc_q;
    timestamp_t    time_q;

    logic [31:0] burst_addr;   // start address of the burst being issued
    logic [2:0]  hdr_left;
    logic [15:0] words_left;   // payload words not yet issued
    logic [2:0]  beats_left;   // beats left in current payload burst
    logic [2:0]  burst_bc;
    logic        in_burst;
    logic [16:0] acc_left;     // beats still to be accepted at memory

    logic        cmd_valid_q;
    mem_cmd_t    cmd_q;

    logic        adv;
    logic        hdr_load;
    logic        pay_load;
    logic        burst_go;
    logic        last_accept;
    logic [2:0]  next_bc;
    logic [31:0] hdr_word;

    assign o_ready = (state == IDLE);
    assign o_done = (state == DONE);
    assign o_cmd_valid = cmd_valid_q;
    assign o_cmd = cmd_q;

    // output register free or draining this cycle
    assign adv = !cmd_valid_q || i_cmd_ready;

    assign next_bc = (words_left >= 16'(`PCAP_BURST_MAX)) ? 3'(`PCAP_BURST_MAX)
                                                           : words_left[2:0];

    // whole burst must sit in the FIFO before it starts
    assign burst_go = (state == WR_PAYLOAD) && !in_burst && (words_left != '0)
                      && (i_fifo_usedw >= UW'(next_bc));

    assign hdr_load = ((state == PREP) || (state == WR_HEADER)) && (hdr_left != '0) && adv;
    assign pay_load = (state == WR_PAYLOAD) && in_burst && !i_fifo_empty && adv;
    assign o_fifo_rd = pay_load;

    assign last_accept = i_mem_accept && (acc_left == 17'd1);

    always_comb begin
        case (hdr_left)
            3'd4:    hdr_word = time_q.sec;
            3'd3:    hdr_word = time_q.nsec;
            default: hdr_word = {16'd0, desc_q.len};   // length, twice
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE:       if (i_start) state_next = PREP;
            PREP:       state_next = WR_HEADER;
            WR_HEADER:  if (hdr_load && hdr_left == 3'd1) state_next = WR_PAYLOAD;
            WR_PAYLOAD: state_next = WR_PAYLOAD;   // left only by last_accept
            DONE:       state_next = IDLE;
            default:    state_next = IDLE;
        endcase
        if (last_accept) begin
            state_next = DONE;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state <= IDLE;
            cmd_valid_q <= 1'b0;
            in_burst <= 1'b0;
            hdr_left <= '0;
            words_left <= '0;
            beats_left <= '0;
            acc_left <= '0;
        end else begin
            state <= state_next;

            if (adv) begin
                cmd_valid_q <= hdr_load || pay_load;
            end

            if (state == IDLE && i_start) begin
                hdr_left <= 3'(`PCAP_HDR_WORDS);
                words_left <= i_desc.len;
                acc_left <= {1'b0, i_desc.len} + 17'(`PCAP_HDR_WORDS);
            end else begin
                if (hdr_load) begin
                    hdr_left <= hdr_left - 1'b1;
                end
                if (pay_load) begin
                    words_left <= words_left - 1'b1;
                end
                if (i_mem_accept && acc_left != '0) begin
                    acc_left <= acc_left - 1'b1;
                end
            end

            if (burst_go) begin
                in_burst <= 1'b1;
                beats_left <= next_bc;
            end else if (pay_load) begin
                beats_left <= beats_left - 1'b1;
                if (beats_left == 3'd1) begin
                    in_burst <= 1'b0;
                end
            end
        end
    end

    // descriptor and time captured together
    always_ff @(posedge clk) begin
        if (state == IDLE && i_start) begin
            desc_q <= i_desc;
            time_q <= i_time;
            burst_addr <= i_desc.addr;
        end else if ((hdr_load && hdr_left == 3'd1) || (pay_load && beats_left == 3'd1)) begin
            burst_addr <= burst_addr + 32'(BURST_BYTES);   // next burst
        end

        if (burst_go) begin
            burst_bc <= next_bc;
        end

        // holds the last word while downstream stalls
        if (hdr_load) begin
            cmd_q <= '{addr: burst_addr, burstcount: 3'(`PCAP_HDR_WORDS), data: hdr_word};
        end else if (pay_load) begin
            cmd_q <= '{addr: burst_addr, burstcount: burst_bc, data: i_fifo_data};
        end
    end

endmodule

/* source/skid_buffer.sv */
`timescale 1ns/1ps

module skid_buffer (
    input  logic                clk,
    input  logic                reset,
    input  logic                i_valid,
    input  pcap_pkg::mem_cmd_t  i_data,
    output logic                o_ready,
    output logic                o_valid,
    output pcap_pkg::mem_cmd_t  o_data,
    input  logic                i_ready
);
    import pcap_pkg::*;

    logic     buf_valid;
    mem_cmd_t buf_data;

    // ready only depends on the held beat, never on i_ready directly
    assign o_ready = !buf_valid;

    // held beat goes first to keep order
    assign o_valid = buf_valid || i_valid;
    assign o_data = buf_valid ? buf_data : i_data;

    always_ff @(posedge clk) begin
        if (!reset) begin
            buf_valid <= 1'b0;
        end else if (buf_valid) begin
            if (i_ready) begin
                buf_valid <= 1'b0;   // held beat drained
            end
        end else if (i_valid && !i_ready) begin
            buf_valid <= 1'b1;   // accepted but downstream stalled
        end
    end

    always_ff @(posedge clk) begin
        if (!buf_valid && i_valid) begin
            buf_data <= i_data;
        end
    end

endmodule

/* source/pkt_fifo.sv */
`timescale 1ns/1ps
`include "pcap_defs.svh"

module pkt_fifo (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       i_wr_en,
    input  logic [31:0]                i_wr_data,
    input  logic                       i_rd_en,
    output logic [31:0]                o_rd_data,
    output logic                       o_empty,
    output logic                       o_full,
    output logic [`PCAP_USEDW_W-1:0]   o_usedw
);
    localparam int DEPTH = `PCAP_FIFO_DEPTH;
    localparam int AW = $clog2(DEPTH);
    localparam int UW = `PCAP_USEDW_W;

    logic [31:0]   mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic          do_wr;
    logic          do_rd;

    assign do_wr = i_wr_en && !o_full;   // writes into a full FIFO are dropped
    assign do_rd = i_rd_en && !o_empty;

    // head word always visible
    assign o_rd_data = mem[rd_ptr];
    assign o_empty = (o_usedw == '0);
    assign o_full = (o_usedw == UW'(DEPTH));

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            o_usedw <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   o_usedw <= o_usedw + 1'b1;
                2'b01:   o_usedw <= o_usedw - 1'b1;
                default: o_usedw <= o_usedw;   // both or neither
            endcase
        end
    end

endmodule

/* source/pcap_pkg.sv */
package pcap_pkg;

    // start request for one packet
    typedef struct packed {
        logic [31:0] addr;   // byte address of the header
        logic [15:0] len;    // payload length in words
    } capture_desc_t;

    // one beat on the memory write port
    typedef struct packed {
        logic [31:0] addr;        // burst start address, same for all beats
        logic [2:0]  burstcount;  // 1..4
        logic [31:0] data;
    } mem_cmd_t;

    // time of day as seen at the start of capture
    typedef struct packed {
        logic [31:0] sec;
        logic [31:0] nsec;
    } timestamp_t;

    // capture writer sequencing
    typedef enum logic [2:0] {
        IDLE,
        PREP,
        WR_HEADER,
        WR_PAYLOAD,
        DONE
    } writer_state_e;

endpackage

/* source/pcap_defs.svh */
`ifndef PCAP_DEFS_SVH
`define PCAP_DEFS_SVH

// packet FIFO size per channel, in 32-bit words
`define PCAP_FIFO_DEPTH 16

// fill count width, must hold the value DEPTH itself
`define PCAP_USEDW_W ($clog2(`PCAP_FIFO_DEPTH + 1))

// longest memory burst in words
`define PCAP_BURST_MAX 4

// seconds, nanoseconds, length, length
`define PCAP_HDR_WORDS 4

// peer capture channels sharing the memory port
`define PCAP_CHANNELS 2

`endif
